// ==== common/cache_pkg.sv ====
// shared geometry, address decode and control/request types for the L1 cache
`default_nettype none

package cache_pkg;

    localparam int S_OFFSET = 5;
    localparam int S_INDEX  = 3;
    localparam int S_TAG    = 32 - S_OFFSET - S_INDEX;
    localparam int S_MASK   = 2**S_OFFSET;     // bytes per line
    localparam int S_LINE   = 8*S_MASK;        // bits per line
    localparam int NUM_SETS = 2**S_INDEX;

    typedef logic [S_LINE-1:0] line_t;
    typedef logic [S_MASK-1:0] byte_en_t;

    typedef struct packed {
        logic [S_TAG-1:0]    tag;
        logic [S_INDEX-1:0]  index;
        logic [S_OFFSET-1:0] offset;
    } addr_fields_t;

    // same 32 bits, seen as a bus word or as cache fields
    typedef union packed {
        logic [31:0]  word;
        addr_fields_t f;
    } cache_addr_t;

    typedef struct packed {
        logic        write;
        cache_addr_t addr;
        byte_en_t    byte_en;
        line_t       wdata;
    } cpu_req_t;

    typedef struct packed {
        logic set_dirty;
        logic reset_dirty;
        logic set_valid;
        logic load_tag;
        logic set_lru;
        logic load_data;
        logic pmem_write;
    } dp_ctrl_t;

    typedef struct packed {
        logic hit;
        logic victim_dirty;
    } dp_status_t;

endpackage : cache_pkg

`default_nettype wire

// ==== cache/array.sv ====
// per-set register array for tags and flag bits, read registered with same-cycle write-through
`default_nettype none

module array
    import cache_pkg::*;
#(
    parameter int width = 1
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               read,
    input  logic               load,
    input  logic [S_INDEX-1:0] rindex,
    input  logic [S_INDEX-1:0] windex,
    input  logic [width-1:0]   datain,
    output logic [width-1:0]   dataout
);

    logic [width-1:0] data [NUM_SETS];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_SETS; i++)
            begin
                data[i] <= '0;
            end
            dataout <= '0;
        end
        else
        begin
            if (read)
            begin
                dataout <= (load && (windex == rindex)) ? datain : data[rindex]; // forward new entry
            end
            if (load)
            begin
                data[windex] <= datain;
            end
        end
    end

endmodule : array

`default_nettype wire

// ==== cache/data_array.sv ====
// line storage for one way, byte-granular writes and a registered read port
`default_nettype none

module data_array
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               read,
    input  byte_en_t           write_en,
    input  logic [S_INDEX-1:0] rindex,
    input  logic [S_INDEX-1:0] windex,
    input  line_t              datain,
    output line_t              dataout
);

    line_t mem [NUM_SETS];

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < S_MASK; i++)
        begin
            if (write_en[i])
            begin
                mem[windex][8*i +: 8] <= datain[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dataout <= '0;
        end
        else if (read)
        begin
            for (int i = 0; i < S_MASK; i++)
            begin
                if (write_en[i] && (windex == rindex))
                    dataout[8*i +: 8] <= datain[8*i +: 8];   // merge bytes being written
                else
                    dataout[8*i +: 8] <= mem[rindex][8*i +: 8];
            end
        end
    end

endmodule : data_array

`default_nettype wire

// ==== cache/cache_datapath.sv ====
// two-way cache datapath: tag compare, way steering, LRU and pmem address/data muxing
`default_nettype none

module cache_datapath
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  cpu_req_t    req,
    input  dp_ctrl_t    ctrl,
    input  line_t       pmem_rdata,
    output dp_status_t  status,
    output line_t       mem_rdata,
    output line_t       pmem_wdata,
    output cache_addr_t pmem_address
);

    cache_addr_t      addr;
    logic [S_TAG-1:0] way_tag [2];
    logic [1:0]       way_valid;
    logic [1:0]       way_dirty;
    logic [1:0]       way_hit;
    line_t            way_line [2];
    byte_en_t         way_we [2];
    logic             lru;          // way to evict next
    logic             lru_in;
    logic             tgt;          // way written this cycle
    line_t            line_in;
    byte_en_t         line_be;

    assign addr = req.addr;

    assign status.hit          = |way_hit;
    assign status.victim_dirty = way_dirty[lru];

    // hit way on a store, LRU way on a fill
    assign tgt = status.hit ? way_hit[1] : lru;

    assign lru_in = !way_hit[1];    // other way becomes LRU

    // store data under the byte mask, otherwise a whole pmem line
    assign line_in = ctrl.set_dirty ? req.wdata : pmem_rdata;
    assign line_be = ctrl.set_dirty ? req.byte_en : '1;

    assign mem_rdata  = way_line[way_hit[1]];
    assign pmem_wdata = way_line[lru];

    always_comb
    begin
        pmem_address          = addr;
        pmem_address.f.offset = '0;
        if (ctrl.pmem_write)
        begin
            pmem_address.f.tag = way_tag[lru];   // victim's own line
        end
    end

    for (genvar w = 0; w < 2; w++)
    begin : g_way
        logic sel;

        assign sel        = (tgt == 1'(w));
        assign way_hit[w] = way_valid[w] && (way_tag[w] == addr.f.tag);
        assign way_we[w]  = (ctrl.load_data && sel) ? line_be : '0;

        data_array line_array (
            .clk      (clk),
            .rst_n    (rst_n),
            .read     (1'b1),           // arrays follow the request index
            .write_en (way_we[w]),
            .rindex   (addr.f.index),
            .windex   (addr.f.index),
            .datain   (line_in),
            .dataout  (way_line[w])
        );

        array #(.width(S_TAG)) tag_array (
            .clk     (clk),
            .rst_n   (rst_n),
            .read    (1'b1),
            .load    (ctrl.load_tag && sel),
            .rindex  (addr.f.index),
            .windex  (addr.f.index),
            .datain  (addr.f.tag),
            .dataout (way_tag[w])
        );

        array #(.width(1)) valid_array (
            .clk     (clk),
            .rst_n   (rst_n),
            .read    (1'b1),
            .load    (ctrl.set_valid && sel),
            .rindex  (addr.f.index),
            .windex  (addr.f.index),
            .datain  (1'b1),
            .dataout (way_valid[w])
        );

        array #(.width(1)) dirty_array (
            .clk     (clk),
            .rst_n   (rst_n),
            .read    (1'b1),
            .load    ((ctrl.set_dirty || ctrl.reset_dirty) && sel),
            .rindex  (addr.f.index),
            .windex  (addr.f.index),
            .datain  (ctrl.set_dirty),     // set on store, clear on fill
            .dataout (way_dirty[w])
        );
    end

    array #(.width(1)) lru_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .read    (1'b1),
        .load    (ctrl.set_lru),
        .rindex  (addr.f.index),
        .windex  (addr.f.index),
        .datain  (lru_in),
        .dataout (lru)
    );

endmodule : cache_datapath

`default_nettype wire

// ==== cache/cache_control.sv ====
// cache FSM sequencing compare, write-back, allocate and respond over two four-phase handshakes
`default_nettype none

module cache_control
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       mem_req,
    input  logic       write,
    input  dp_status_t status,
    input  logic       pmem_ack,
    output dp_ctrl_t   ctrl,
    output logic       mem_ack,
    output logic       pmem_req,
    output logic       pmem_write
);

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_write_back,
        st_allocate,
        st_respond
    } state_t;

    state_t state;
    state_t next_state;
    logic   ack_seen;       // pmem ack taken, waiting for it to fall
    logic   pmem_rise;
    logic   pmem_done;

    assign pmem_rise  = pmem_ack && !ack_seen;
    assign pmem_done  = ack_seen && !pmem_ack;
    assign pmem_write = ctrl.pmem_write;

    always_comb
    begin
        next_state = state;
        ctrl       = '0;
        pmem_req   = 1'b0;

        case (state)
            st_idle:
            begin
                if (mem_req)
                    next_state = st_compare;
            end

            st_compare:
            begin
                if (status.hit)
                begin
                    ctrl.set_lru = 1'b1;
                    if (write)
                    begin
                        ctrl.load_data = 1'b1;
                        ctrl.set_dirty = 1'b1;   // store merges into hit way
                    end
                    next_state = st_respond;
                end
                else if (status.victim_dirty)
                begin
                    next_state = st_write_back;
                end
                else
                begin
                    next_state = st_allocate;
                end
            end

            st_write_back:
            begin
                ctrl.pmem_write = 1'b1;           // holds victim address too
                pmem_req        = !ack_seen;
                if (pmem_done)
                    next_state = st_allocate;
            end

            st_allocate:
            begin
                pmem_req = !ack_seen;
                if (pmem_rise)
                begin
                    ctrl.load_data   = 1'b1;
                    ctrl.set_valid   = 1'b1;
                    ctrl.load_tag    = 1'b1;
                    ctrl.reset_dirty = 1'b1;
                end
                if (pmem_done)
                    next_state = st_compare;      // retry, now a hit
            end

            st_respond:
            begin
                if (!mem_req)
                    next_state = st_idle;
            end

            default:
            begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= st_idle;
            ack_seen <= 1'b0;
            mem_ack  <= 1'b0;
        end
        else
        begin
            state <= next_state;

            if (pmem_rise && (state == st_write_back || state == st_allocate))
                ack_seen <= 1'b1;
            else if (pmem_done)
                ack_seen <= 1'b0;

            // one cycle behind respond, dropped once req falls
            mem_ack <= (state == st_respond) && mem_req;
        end
    end

endmodule : cache_control

`default_nettype wire

// ==== rtl/l1_cache.sv ====
// L1 cache top joining the control FSM and datapath to the requester and pmem ports
`default_nettype none

module l1_cache
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // requester side
    input  logic        mem_req,
    input  cpu_req_t    req,
    output logic        mem_ack,
    output line_t       mem_rdata,

    // physical memory side
    output logic        pmem_req,
    output logic        pmem_write,
    output cache_addr_t pmem_address,
    output line_t       pmem_wdata,
    input  logic        pmem_ack,
    input  line_t       pmem_rdata
);

    dp_ctrl_t   ctrl;
    dp_status_t status;

    cache_control control_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_req    (mem_req),
        .write      (req.write),
        .status     (status),
        .pmem_ack   (pmem_ack),
        .ctrl       (ctrl),
        .mem_ack    (mem_ack),
        .pmem_req   (pmem_req),
        .pmem_write (pmem_write)
    );

    cache_datapath datapath_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .ctrl         (ctrl),
        .pmem_rdata   (pmem_rdata),
        .status       (status),
        .mem_rdata    (mem_rdata),
        .pmem_wdata   (pmem_wdata),
        .pmem_address (pmem_address)
    );

endmodule : l1_cache

`default_nettype wire

// ==== tests/pmem_model.sv ====
// behavioral physical memory for the testbench, answers four-phase line reads and writes
`default_nettype none

module pmem_model
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pmem_req,
    input  logic        pmem_write,
    input  cache_addr_t pmem_address,
    input  line_t       pmem_wdata,
    output logic        pmem_ack,
    output line_t       pmem_rdata,
    output int          read_count,
    output int          write_count,
    output logic [31:0] last_waddr,
    output line_t       last_wdata
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LATENCY = 3;

    line_t mem [logic [26:0]];     // only lines written back
    int    wait_cnt;

    function automatic line_t stored_line(input logic [26:0] la);
        line_t l;
        if (mem.exists(la))
            return mem[la];
        for (int w = 0; w < 8; w++)
        begin
            l[32*w +: 32] = ({la, 5'b0} + 32'(4*w)) ^ 32'hA5A5A5A5;  // byte address pattern
        end
        return l;
    endfunction

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pmem_ack    <= 1'b0;
            pmem_rdata  <= '0;
            wait_cnt    <= 0;
            read_count  <= 0;
            write_count <= 0;
            last_waddr  <= '0;
            last_wdata  <= '0;
        end
        else if (pmem_req && !pmem_ack)
        begin
            if (wait_cnt < LATENCY)
                wait_cnt <= wait_cnt + 1;
            else
            begin
                wait_cnt <= 0;
                pmem_ack <= 1'b1;
                if (pmem_write)
                begin
                    mem[pmem_address.word[31:5]] = pmem_wdata;
                    write_count <= write_count + 1;
                    last_waddr  <= pmem_address.word;
                    last_wdata  <= pmem_wdata;
                end
                else
                begin
                    pmem_rdata <= stored_line(pmem_address.word[31:5]);
                    read_count <= read_count + 1;
                end
            end
        end
        else if (!pmem_req)
        begin
            pmem_ack <= 1'b0;           // release once the cache drops req
        end
    end

endmodule : pmem_model

`default_nettype wire

// ==== tests/tb_l1_cache.sv ====
// testbench for the L1 cache, runs directed requests from the stimulus file then LCG traffic
`default_nettype none

module tb_l1_cache
    import cache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAND_REQS      = 40;
    localparam int CYCLES_PER_REQ = 200;
    localparam int HIT_EDGES      = 3;      // ack two edges after req is sampled

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [7:0]  wmask;                 // one bit per 32-bit word
        logic [31:0] fill;
        logic [31:0] exp_word;
    } stim_t;

    logic        clk;
    logic        rst_n;
    logic        mem_req;
    cpu_req_t    req;
    logic        mem_ack;
    line_t       mem_rdata;
    logic        pmem_req;
    logic        pmem_write;
    cache_addr_t pmem_address;
    line_t       pmem_wdata;
    logic        pmem_ack;
    line_t       pmem_rdata;
    int          read_count;
    int          write_count;
    logic [31:0] last_waddr;
    line_t       last_wdata;

    stim_t            stim_q [$];
    string            name_q [$];
    line_t            shadow [logic [26:0]];  // line contents as the requester sees them
    logic [S_TAG-1:0] ref_tag [NUM_SETS][2];
    logic             ref_valid [NUM_SETS][2];
    logic             ref_dirty [NUM_SETS][2];
    logic             ref_lru [NUM_SETS];     // way to evict next
    logic [S_TAG-1:0] rand_tags [4] = '{24'h000001, 24'h000002, 24'h000003, 24'h800000};
    logic [31:0]      lcg_state;
    int               total_reqs;
    int               errors;
    int               tests_run;
    int               tests_failed;

    l1_cache l1_cache_inst (.*);
    pmem_model pmem_inst (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic line_t shadow_line(input logic [26:0] la);
        line_t l;
        if (shadow.exists(la))
            return shadow[la];
        for (int w = 0; w < 8; w++)
        begin
            l[32*w +: 32] = ({la, 5'b0} + 32'(4*w)) ^ 32'hA5A5A5A5;  // memory power-up pattern
        end
        return l;
    endfunction

    task automatic report_mismatch(input string test, input string what,
                                   input line_t expected, input line_t actual);
        $display("CHECK FAILED %s %s: expected %0h actual %0h", test, what, expected, actual);
        errors++;
    endtask

    // two-way LRU write-back cache, tracked at tag level only
    task automatic predict_access(input cache_addr_t a, input logic wr, output logic hit,
                                  output logic wb, output logic [31:0] victim);
        logic [S_INDEX-1:0] idx;
        logic               w;
        idx = a.f.index;
        hit = 1'b0;
        w   = ref_lru[idx];
        for (int i = 0; i < 2; i++)
        begin
            if (ref_valid[idx][i] && ref_tag[idx][i] == a.f.tag)
            begin
                hit = 1'b1;
                w   = 1'(i);
            end
        end
        wb     = !hit && ref_valid[idx][w] && ref_dirty[idx][w];
        victim = {ref_tag[idx][w], idx, 5'b0};
        if (!hit)
        begin
            ref_valid[idx][w] = 1'b1;
            ref_tag[idx][w]   = a.f.tag;
            ref_dirty[idx][w] = 1'b0;
        end
        if (wr)
            ref_dirty[idx][w] = 1'b1;
        ref_lru[idx] = !w;
    endtask

    task automatic load_stimulus();
        int          fd;
        string       text;
        string       test;
        string       op;
        logic [31:0] a;
        logic [7:0]  m;
        logic [31:0] f;
        logic [31:0] e;
        fd = $fopen("tests/cache_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file tests/cache_stimulus.txt");
            errors++;
        end
        else
        begin
            while ($fgets(text, fd) != 0)
            begin
                if (text.len() > 1 && text[0] != "#" &&
                    $sscanf(text, "%s %s %h %h %h %h", test, op, a, m, f, e) == 6)
                begin
                    stim_q.push_back('{write: (op == "W"), addr: a, wmask: m, fill: f,
                                       exp_word: e});
                    name_q.push_back(test);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_request(input string test, input stim_t s, input logic check_word);
        cache_addr_t a;
        logic        exp_hit;
        logic        exp_wb;
        logic [31:0] victim;
        line_t       exp_line;
        line_t       victim_line;
        line_t       got;
        int          reads0;
        int          writes0;
        int          edges;
        int          errs0;
        int          word_lsb;

        a        = s.addr;
        errs0    = errors;
        word_lsb = 32 * int'(a.f.offset[4:2]);
        exp_line = shadow_line(a.word[31:5]);
        predict_access(a, s.write, exp_hit, exp_wb, victim);
        victim_line = shadow_line(victim[31:5]);
        for (int w = 0; w < 8; w++)
        begin
            if (s.write && s.wmask[w])
                exp_line[32*w +: 32] = s.fill;
        end
        if (s.write)
            shadow[a.word[31:5]] = exp_line;
        reads0  = read_count;
        writes0 = write_count;

        @(negedge clk);
        req.write = s.write;
        req.addr  = a;
        for (int b = 0; b < S_MASK; b++)
            req.byte_en[b] = s.wmask[b/4];
        req.wdata = {8{s.fill}};
        mem_req   = 1'b1;
        edges     = 0;
        do
        begin
            @(negedge clk);
            edges++;
        end
        while (!mem_ack);
        got     = mem_rdata;
        mem_req = 1'b0;
        while (mem_ack)
            @(negedge clk);

        if (got !== exp_line)
            report_mismatch(test, "line", exp_line, got);
        if (check_word && got[word_lsb +: 32] !== s.exp_word)
            report_mismatch(test, "word", line_t'(s.exp_word), line_t'(got[word_lsb +: 32]));
        if (read_count - reads0 != (exp_hit ? 0 : 1))
            report_mismatch(test, "pmem reads", line_t'(!exp_hit), line_t'(read_count - reads0));
        if (write_count - writes0 != int'(exp_wb))
            report_mismatch(test, "pmem writes", line_t'(exp_wb), line_t'(write_count - writes0));
        if (exp_hit && edges != HIT_EDGES)
            report_mismatch(test, "hit latency", line_t'(HIT_EDGES), line_t'(edges));
        if (exp_wb && last_waddr !== victim)
            report_mismatch(test, "write-back address", line_t'(victim), line_t'(last_waddr));
        if (exp_wb && last_wdata !== victim_line)
            report_mismatch(test, "write-back data", victim_line, last_wdata);

        tests_run++;
        if (errors == errs0)
            $display("test %s ok", test);
        else
        begin
            tests_failed++;
            $display("test %s error", test);
        end
    endtask

    initial
    begin
        stim_t       s;
        logic [31:0] r;
        rst_n        = 1'b0;
        mem_req      = 1'b0;
        req          = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        total_reqs   = 0;
        lcg_state    = 32'd68669;
        for (int i = 0; i < NUM_SETS; i++)
        begin
            ref_lru[i] = 1'b0;
            for (int w = 0; w < 2; w++)
            begin
                ref_valid[i][w] = 1'b0;
                ref_dirty[i][w] = 1'b0;
                ref_tag[i][w]   = '0;
            end
        end
        load_stimulus();
        total_reqs = stim_q.size() + RAND_REQS;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        foreach (stim_q[i])
            run_request(name_q[i], stim_q[i], 1'b1);

        for (int i = 0; i < RAND_REQS; i++)
        begin
            r          = lcg_next();
            s.write    = r[24];
            s.addr     = {rand_tags[r[17:16]], r[20:18], r[23:21], 2'b00};  // upper LCG bits
            r          = lcg_next();
            s.wmask    = r[23:16];
            s.fill     = lcg_next();
            s.exp_word = '0;
            run_request($sformatf("random_%0d", i), s, 1'b0);
        end

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        wait (total_reqs > 0);
        repeat (total_reqs * CYCLES_PER_REQ + 8) @(posedge clk);
        $display("timeout: the cache stopped answering requests");
        $display("Simulation failed");
        $finish;
    end

endmodule : tb_l1_cache

`default_nettype wire

// ==== tests/cache_stimulus.txt ====
# columns: test name, op (R or W), byte address, word mask, fill word, expected word at address
# all numbers hex, the fill word goes to every 32-bit word the mask enables
cold_read      R 00000124 00 00000000 a5a5a481
hit_read       R 00000128 00 00000000 a5a5a48d
partial_store  W 00000120 05 deadbeef deadbeef
merged_word0   R 00000120 00 00000000 deadbeef
merged_word1   R 00000124 00 00000000 a5a5a481
merged_word2   R 00000128 00 00000000 deadbeef
fill_way_b     R 0000022c 00 00000000 a5a5a789
touch_way_a    R 00000130 00 00000000 a5a5a495
evict_lru_b    R 00000334 00 00000000 a5a5a691
a_still_hits   R 0000013c 00 00000000 a5a5a499
refill_b       R 00000220 00 00000000 a5a5a785
evict_dirty_a  R 00000320 00 00000000 a5a5a685
reread_dirty   R 00000128 00 00000000 deadbeef
reread_hit     R 00000124 00 00000000 a5a5a481
store_miss     W 000004a8 ff 12345678 12345678
store_readback R 000004bc 00 00000000 12345678
high_tag_read  R 80000044 00 00000000 25a5a5e1

// ==== l1_cache.f ====
common/cache_pkg.sv
cache/array.sv
cache/data_array.sv
cache/cache_datapath.sv
cache/cache_control.sv
rtl/l1_cache.sv
tests/pmem_model.sv
tests/tb_l1_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the L1 cache testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_l1_cache -Mdir obj_dir -f l1_cache.f

./obj_dir/Vtb_l1_cache | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
grep -q "Simulation passed" sim.log
